// ==== verilog/fpu_ss_defs.svh ====
`ifndef FPU_SS_DEFS_SVH
`define FPU_SS_DEFS_SVH

// Datapath and register file geometry
`define FPU_SS_XLEN     32
`define FPU_SS_NUM_FPR  32
`define FPU_SS_RADDR_W  5

// Width of the offload id
`define FPU_SS_ID_W     4

// Rounding mode field
`define FPU_SS_FRM_W    3

// Major opcodes
`define FPU_SS_OPCODE_OP_FP   7'b1010011
`define FPU_SS_OPCODE_SYSTEM  7'b1110011

`endif

// ==== verilog/fpu_ss_instr_pkg.sv ====
`default_nettype none

`include "fpu_ss_defs.svh"

package fpu_ss_instr_pkg;

  // Operations handled by the subsystem
  typedef enum logic [2:0] {
    OP_NONE   = 3'd0,
    OP_SGNJ   = 3'd1,
    OP_SGNJN  = 3'd2,
    OP_SGNJX  = 3'd3,
    OP_MV_X_W = 3'd4,
    OP_MV_W_X = 3'd5,
    OP_CSRRW  = 3'd6
  } fpu_op_e;

  // funct7 of the OP-FP major opcode
  localparam logic [6:0] FUNCT7_SGNJ   = 7'b0010000;
  localparam logic [6:0] FUNCT7_MV_X_W = 7'b1110000;
  localparam logic [6:0] FUNCT7_MV_W_X = 7'b1111000;

  // funct3 of the SYSTEM major opcode
  localparam logic [2:0] FUNCT3_CSRRW  = 3'b001;

endpackage

`default_nettype wire

// ==== verilog/fpu_ss_csr_pkg.sv ====
`default_nettype none

`include "fpu_ss_defs.svh"

package fpu_ss_csr_pkg;

  // Only frm is implemented
  typedef enum logic [11:0] {
    CSR_FRM = 12'h002
  } csr_addr_e;

  typedef enum logic [`FPU_SS_FRM_W-1:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100,
    DYN = 3'b111
  } roundmode_e;

endpackage

`default_nettype wire

// ==== verilog/fpu_ss_decoder.sv ====
`default_nettype none

`include "fpu_ss_defs.svh"

module fpu_ss_decoder (
  input  logic [`FPU_SS_XLEN-1:0]    instr_i,
  output fpu_ss_instr_pkg::fpu_op_e  op_o,
  output logic [`FPU_SS_RADDR_W-1:0] rs1_o,
  output logic [`FPU_SS_RADDR_W-1:0] rs2_o,
  output logic [`FPU_SS_RADDR_W-1:0] rd_o,
  output logic                       rs1_is_fp_o,
  output logic                       rs2_is_fp_o,
  output logic                       accept_o
);

  logic [6:0]  opcode;
  logic [6:0]  funct7;
  logic [2:0]  funct3;
  logic [11:0] csr_addr;

  // Standard R-type fields
  assign opcode   = instr_i[6:0];
  assign funct3   = instr_i[14:12];
  assign funct7   = instr_i[31:25];
  assign csr_addr = instr_i[31:20];
  assign rs1_o    = instr_i[19:15];
  assign rs2_o    = instr_i[24:20];
  assign rd_o     = instr_i[11:7];

  always_comb begin
    op_o        = fpu_ss_instr_pkg::OP_NONE;
    accept_o    = 1'b0;
    rs1_is_fp_o = 1'b0;
    rs2_is_fp_o = 1'b0;
    case (opcode)
      `FPU_SS_OPCODE_OP_FP: begin
        if (funct7 == fpu_ss_instr_pkg::FUNCT7_SGNJ && funct3 <= 3'b010) begin
          // funct3 picks J, JN or JX
          case (funct3)
            3'b000:  op_o = fpu_ss_instr_pkg::OP_SGNJ;
            3'b001:  op_o = fpu_ss_instr_pkg::OP_SGNJN;
            default: op_o = fpu_ss_instr_pkg::OP_SGNJX;
          endcase
          accept_o    = 1'b1;
          rs1_is_fp_o = 1'b1;
          rs2_is_fp_o = 1'b1;
        end else if (rs2_o == '0 && funct3 == 3'b000) begin
          if (funct7 == fpu_ss_instr_pkg::FUNCT7_MV_X_W) begin
            op_o        = fpu_ss_instr_pkg::OP_MV_X_W;
            accept_o    = 1'b1;
            rs1_is_fp_o = 1'b1;
          end else if (funct7 == fpu_ss_instr_pkg::FUNCT7_MV_W_X) begin
            op_o     = fpu_ss_instr_pkg::OP_MV_W_X;
            accept_o = 1'b1;
          end
        end
      end
      `FPU_SS_OPCODE_SYSTEM: begin
        // Only CSRRW on frm
        if (funct3 == fpu_ss_instr_pkg::FUNCT3_CSRRW &&
            csr_addr == fpu_ss_csr_pkg::CSR_FRM) begin
          op_o     = fpu_ss_instr_pkg::OP_CSRRW;
          accept_o = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/fpu_ss_regfile.sv ====
`default_nettype none

`include "fpu_ss_defs.svh"

module fpu_ss_regfile (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic [`FPU_SS_RADDR_W-1:0] raddr_a_i,
  input  logic [`FPU_SS_RADDR_W-1:0] raddr_b_i,
  output logic [`FPU_SS_XLEN-1:0]    rdata_a_o,
  output logic [`FPU_SS_XLEN-1:0]    rdata_b_o,
  input  logic                       we_i,
  input  logic [`FPU_SS_RADDR_W-1:0] waddr_i,
  input  logic [`FPU_SS_XLEN-1:0]    wdata_i
);

  logic [`FPU_SS_XLEN-1:0] regs_q [`FPU_SS_NUM_FPR];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `FPU_SS_NUM_FPR; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Reads are combinational, write lands at the edge
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

  a_waddr_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    we_i |-> !$isunknown(waddr_i));

endmodule

`default_nettype wire

// ==== verilog/fpu_ss_csr.sv ====
`default_nettype none

`include "fpu_ss_defs.svh"

module fpu_ss_csr (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     csr_we_i,
  input  logic [`FPU_SS_FRM_W-1:0] wdata_i,
  output logic [`FPU_SS_FRM_W-1:0] frm_o
);

  fpu_ss_csr_pkg::roundmode_e frm_q;

  // --------------------
  // frm register
  // --------------------
  // CSRRW swaps in the low bits of rs1; the old value is
  // read combinationally and captured downstream on the same edge
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      frm_q <= fpu_ss_csr_pkg::RNE;
    end else if (csr_we_i) begin
      frm_q <= fpu_ss_csr_pkg::roundmode_e'(wdata_i);
    end
  end

  assign frm_o = frm_q;

endmodule

`default_nettype wire

// ==== verilog/fpu_ss_controller.sv ====
`default_nettype none

`include "fpu_ss_defs.svh"

module fpu_ss_controller (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       issue_valid_i,
  input  logic                       accept_i,
  input  fpu_ss_instr_pkg::fpu_op_e  op_i,
  input  logic [`FPU_SS_RADDR_W-1:0] rs1_i,
  input  logic [`FPU_SS_RADDR_W-1:0] rs2_i,
  input  logic                       rs1_is_fp_i,
  input  logic                       rs2_is_fp_i,
  input  logic                       stage_valid_i,
  input  logic                       stage_fp_dest_i,
  input  logic [`FPU_SS_RADDR_W-1:0] stage_rd_i,
  input  logic                       result_ready_i,
  output logic                       issue_ready_o,
  output logic                       load_o,
  output logic                       csr_we_o
);

  logic [1:0] cnt_q;
  logic       drain;
  logic       hazard;
  logic       fire;

  assign drain = stage_valid_i & result_ready_i;

  // RAW on a pending FP destination, held until the entry has left
  assign hazard = stage_valid_i & stage_fp_dest_i &
                  ((rs1_is_fp_i & (rs1_i == stage_rd_i)) |
                   (rs2_is_fp_i & (rs2_i == stage_rd_i)));

  assign issue_ready_o = ((cnt_q == 2'd0) | drain) & ~hazard;
  assign fire          = issue_valid_i & issue_ready_o;
  assign load_o        = fire & accept_i;
  assign csr_we_o      = load_o & (op_i == fpu_ss_instr_pkg::OP_CSRRW);

  // Outstanding instructions
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= 2'd0;
    end else begin
      cnt_q <= cnt_q + {1'b0, load_o} - {1'b0, drain};
    end
  end

  a_cnt_max: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cnt_q <= 2'd1);

  a_cnt_matches_stage: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cnt_q == {1'b0, stage_valid_i});

endmodule

`default_nettype wire

// ==== verilog/fpu_ss_result_stage.sv ====
`default_nettype none

`include "fpu_ss_defs.svh"

module fpu_ss_result_stage (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       load_i,
  input  fpu_ss_instr_pkg::fpu_op_e  op_i,
  input  logic [`FPU_SS_RADDR_W-1:0] rd_i,
  input  logic [`FPU_SS_ID_W-1:0]    id_i,
  input  logic [`FPU_SS_XLEN-1:0]    fa_i,
  input  logic [`FPU_SS_XLEN-1:0]    fb_i,
  input  logic [`FPU_SS_XLEN-1:0]    int_i,
  input  logic [`FPU_SS_FRM_W-1:0]   frm_i,
  input  logic                       result_ready_i,
  output logic                       result_valid_o,
  output logic                       result_we_o,
  output logic                       fp_dest_o,
  output logic [`FPU_SS_XLEN-1:0]    result_data_o,
  output logic [`FPU_SS_RADDR_W-1:0] result_rd_o,
  output logic [`FPU_SS_ID_W-1:0]    result_id_o,
  output logic                       fpr_we_o
);

  logic [`FPU_SS_XLEN-1:0] res;
  logic                    fp_dest_d;
  logic                    we_d;

  // --------------------
  // Execute
  // --------------------
  always_comb begin
    res       = '0;
    fp_dest_d = 1'b0;
    we_d      = 1'b0;
    case (op_i)
      fpu_ss_instr_pkg::OP_SGNJ: begin
        res       = {fb_i[31], fa_i[30:0]};
        fp_dest_d = 1'b1;
      end
      fpu_ss_instr_pkg::OP_SGNJN: begin
        res       = {~fb_i[31], fa_i[30:0]};
        fp_dest_d = 1'b1;
      end
      fpu_ss_instr_pkg::OP_SGNJX: begin
        res       = {fa_i[31] ^ fb_i[31], fa_i[30:0]};
        fp_dest_d = 1'b1;
      end
      fpu_ss_instr_pkg::OP_MV_W_X: begin
        res       = int_i;
        fp_dest_d = 1'b1;
      end
      fpu_ss_instr_pkg::OP_MV_X_W: begin
        res  = fa_i;
        we_d = 1'b1;
      end
      fpu_ss_instr_pkg::OP_CSRRW: begin
        // Old frm, zero-extended
        res  = {{(`FPU_SS_XLEN - `FPU_SS_FRM_W){1'b0}}, frm_i};
        we_d = 1'b1;
      end
      default: ;
    endcase
  end

  // --------------------
  // Output register
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_valid_o <= 1'b0;
      result_we_o    <= 1'b0;
      fp_dest_o      <= 1'b0;
    end else if (load_i) begin
      result_valid_o <= 1'b1;
      result_we_o    <= we_d;
      fp_dest_o      <= fp_dest_d;
    end else if (result_ready_i) begin
      result_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      result_data_o <= res;
      result_rd_o   <= rd_i;
      result_id_o   <= id_i;
    end
  end

  // FP writeback happens at the result handshake
  assign fpr_we_o = result_valid_o & result_ready_i & fp_dest_o;

  a_hold_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    result_valid_o && !result_ready_i |=> result_valid_o &&
      $stable(result_data_o) && $stable(result_rd_o) &&
      $stable(result_id_o) && $stable(result_we_o));

endmodule

`default_nettype wire

// ==== verilog/fpu_ss.sv ====
`default_nettype none

`include "fpu_ss_defs.svh"

module fpu_ss (
  input  logic                       clk_i,
  input  logic                       arst_n_i,

  // Issue channel
  input  logic                       issue_valid_i,
  input  logic [`FPU_SS_XLEN-1:0]    issue_instr_i,
  input  logic [`FPU_SS_XLEN-1:0]    issue_rs1_i,
  input  logic [`FPU_SS_ID_W-1:0]    issue_id_i,
  output logic                       issue_ready_o,
  output logic                       issue_accept_o,

  // Result channel
  input  logic                       result_ready_i,
  output logic                       result_valid_o,
  output logic [`FPU_SS_XLEN-1:0]    result_data_o,
  output logic [`FPU_SS_RADDR_W-1:0] result_rd_o,
  output logic [`FPU_SS_ID_W-1:0]    result_id_o,
  output logic                       result_we_o
);

  fpu_ss_instr_pkg::fpu_op_e  op;
  logic [`FPU_SS_RADDR_W-1:0] rs1;
  logic [`FPU_SS_RADDR_W-1:0] rs2;
  logic [`FPU_SS_RADDR_W-1:0] rd;
  logic                       rs1_is_fp;
  logic                       rs2_is_fp;
  logic [`FPU_SS_XLEN-1:0]    fpr_a;
  logic [`FPU_SS_XLEN-1:0]    fpr_b;
  logic [`FPU_SS_FRM_W-1:0]   frm;
  logic                       stage_fp_dest;
  logic                       load;
  logic                       csr_we;
  logic                       fpr_we;

  // --------------------
  // Decode and operands
  // --------------------
  fpu_ss_decoder fpu_ss_decoder_i (
    .instr_i     (issue_instr_i),
    .op_o        (op),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .rd_o        (rd),
    .rs1_is_fp_o (rs1_is_fp),
    .rs2_is_fp_o (rs2_is_fp),
    .accept_o    (issue_accept_o)
  );

  // FP registers are written back from the result register
  fpu_ss_regfile fpu_ss_regfile_i (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .rdata_a_o (fpr_a),
    .rdata_b_o (fpr_b),
    .we_i      (fpr_we),
    .waddr_i   (result_rd_o),
    .wdata_i   (result_data_o)
  );

  fpu_ss_csr fpu_ss_csr_i (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .csr_we_i  (csr_we),
    .wdata_i   (issue_rs1_i[`FPU_SS_FRM_W-1:0]),
    .frm_o     (frm)
  );

  // --------------------
  // Control and result
  // --------------------
  fpu_ss_controller fpu_ss_controller_i (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .issue_valid_i   (issue_valid_i),
    .accept_i        (issue_accept_o),
    .op_i            (op),
    .rs1_i           (rs1),
    .rs2_i           (rs2),
    .rs1_is_fp_i     (rs1_is_fp),
    .rs2_is_fp_i     (rs2_is_fp),
    .stage_valid_i   (result_valid_o),
    .stage_fp_dest_i (stage_fp_dest),
    .stage_rd_i      (result_rd_o),
    .result_ready_i  (result_ready_i),
    .issue_ready_o   (issue_ready_o),
    .load_o          (load),
    .csr_we_o        (csr_we)
  );

  fpu_ss_result_stage fpu_ss_result_stage_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .load_i         (load),
    .op_i           (op),
    .rd_i           (rd),
    .id_i           (issue_id_i),
    .fa_i           (fpr_a),
    .fb_i           (fpr_b),
    .int_i          (issue_rs1_i),
    .frm_i          (frm),
    .result_ready_i (result_ready_i),
    .result_valid_o (result_valid_o),
    .result_we_o    (result_we_o),
    .fp_dest_o      (stage_fp_dest),
    .result_data_o  (result_data_o),
    .result_rd_o    (result_rd_o),
    .result_id_o    (result_id_o),
    .fpr_we_o       (fpr_we)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_fpu_ss.sv ====
`default_nettype none

module tb_fpu_ss;

  localparam int SGNJ_ROUNDS = 4;
  localparam int BURST = 8;
  // Moves, sign injection rounds, frm, rejection, burst, dependency
  localparam int NUM_INSTR = 2 + 8 * SGNJ_ROUNDS + 3 + 4 + 2 * BURST + 3;
  localparam int TIMEOUT_CYCLES = 2 * NUM_INSTR + 200;

  logic        clk_i = 1'b0;
  logic        arst_n_i;
  logic        issue_valid_i;
  logic [31:0] issue_instr_i;
  logic [31:0] issue_rs1_i;
  logic [3:0]  issue_id_i;
  logic        issue_ready_o;
  logic        issue_accept_o;
  logic        result_ready_i;
  logic        result_valid_o;
  logic [31:0] result_data_o;
  logic [4:0]  result_rd_o;
  logic [3:0]  result_id_o;
  logic        result_we_o;

  integer      seed = 32'hd480_ef56;
  int          errors = 0;
  int          issued = 0;
  int          accepted = 0;
  int          xfers = 0;
  int          cycles = 0;
  logic [3:0]  next_id = 4'd0;
  logic        exp_accept = 1'b0;
  logic [31:0] fpr_m [32];
  logic [2:0]  frm_m = 3'b000;
  // Expected entry is {we, id, rd, data}
  logic [41:0] exp_q [$];
  logic [41:0] head = '0;
  logic        head_valid = 1'b0;
  logic        pop_pending = 1'b0;
  logic [31:0] op_a [SGNJ_ROUNDS];
  logic [31:0] op_b [SGNJ_ROUNDS];
  logic [31:0] burst_val [BURST];
  logic [31:0] csr_val;

  fpu_ss fpu_ss_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .issue_valid_i  (issue_valid_i),
    .issue_instr_i  (issue_instr_i),
    .issue_rs1_i    (issue_rs1_i),
    .issue_id_i     (issue_id_i),
    .issue_ready_o  (issue_ready_o),
    .issue_accept_o (issue_accept_o),
    .result_ready_i (result_ready_i),
    .result_valid_o (result_valid_o),
    .result_data_o  (result_data_o),
    .result_rd_o    (result_rd_o),
    .result_id_o    (result_id_o),
    .result_we_o    (result_we_o)
  );

  always #5 clk_i = ~clk_i;

  // Random back-pressure on the result channel
  always @(posedge clk_i) begin
    result_ready_i <= ($random(seed) & 3) != 0;
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout hit after %0d cycles, the DUT stopped making progress", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // --------------------
  // Expected queue
  // --------------------
  task automatic refresh_head();
    head_valid = exp_q.size() != 0;
    head = head_valid ? exp_q[0] : '0;
  endtask

  // Head leaves one half cycle after its transfer edge
  always @(negedge clk_i) begin
    if (pop_pending) begin
      xfers = xfers + 1;
      if (exp_q.size() != 0) begin
        exp_q.delete(0);
      end
      refresh_head();
    end
    pop_pending = result_valid_o && result_ready_i;
  end

  a_result: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    result_valid_o && result_ready_i |->
      head_valid && {result_we_o, result_id_o, result_rd_o, result_data_o} == head)
    else begin
      errors++;
      $display("FAIL %0t: got id %0d rd %0d we %0b data %h, expected id %0d rd %0d we %0b data %h",
               $time, $sampled(result_id_o), $sampled(result_rd_o), $sampled(result_we_o),
               $sampled(result_data_o), head[40:37], head[36:32], head[41], head[31:0]);
    end

  a_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    issue_valid_i && issue_ready_o |-> issue_accept_o == exp_accept)
    else begin
      errors++;
      $display("FAIL %0t: accept %0b for instr %h, expected %0b",
               $time, $sampled(issue_accept_o), $sampled(issue_instr_i), $sampled(exp_accept));
    end

  a_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_data_o) &&
      $stable(result_rd_o) && $stable(result_id_o) && $stable(result_we_o))
    else begin
      errors++;
      $display("FAIL %0t: result changed while stalled", $time);
    end

  // A full stage that cannot drain blocks the issue channel
  a_backpressure: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    result_valid_o && !result_ready_i |-> !issue_ready_o)
    else begin
      errors++;
      $display("FAIL %0t: issue ready while the result stage is stalled", $time);
    end

  // --------------------
  // Stimulus
  // --------------------
  function automatic logic [31:0] enc_fp(input logic [6:0] funct7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] funct3,
                                         input logic [4:0] rd);
    return {funct7, rs2, rs1, funct3, rd, 7'b1010011};
  endfunction

  // Holds the request until the handshake, then records the expected result
  task automatic send(input logic [31:0] instr, input logic [31:0] ival, input logic acc,
                      input logic [31:0] data, input logic [4:0] rd, input logic we);
    issue_valid_i <= 1'b1;
    issue_instr_i <= instr;
    issue_rs1_i   <= ival;
    issue_id_i    <= next_id;
    exp_accept    <= acc;
    @(negedge clk_i);
    while (!issue_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    issued = issued + 1;
    if (acc) begin
      accepted = accepted + 1;
      exp_q.push_back({we, next_id, rd, data});
      refresh_head();
    end
    next_id = next_id + 4'd1;
  endtask

  task automatic mv_w_x(input logic [4:0] rd, input logic [31:0] val);
    fpr_m[rd] = val;
    send(enc_fp(7'b1111000, 5'd0, 5'd9, 3'b000, rd), val, 1'b1, val, rd, 1'b0);
  endtask

  task automatic mv_x_w(input logic [4:0] rd, input logic [4:0] fs);
    send(enc_fp(7'b1110000, 5'd0, fs, 3'b000, rd), 32'h0, 1'b1, fpr_m[fs], rd, 1'b1);
  endtask

  task automatic sgnj(input logic [2:0] kind, input logic [4:0] rd,
                      input logic [4:0] fs1, input logic [4:0] fs2);
    logic [31:0] a;
    logic [31:0] b;
    logic        sign;
    a = fpr_m[fs1];
    b = fpr_m[fs2];
    case (kind)
      3'b000:  sign = b[31];
      3'b001:  sign = ~b[31];
      default: sign = a[31] ^ b[31];
    endcase
    fpr_m[rd] = {sign, a[30:0]};
    send(enc_fp(7'b0010000, fs2, fs1, kind, rd), 32'h0, 1'b1, fpr_m[rd], rd, 1'b0);
  endtask

  task automatic csrrw(input logic [4:0] rd, input logic [11:0] addr, input logic [31:0] val);
    logic [31:0] instr;
    logic [31:0] old;
    instr = {addr, 5'd11, 3'b001, rd, 7'b1110011};
    old = {29'd0, frm_m};
    if (addr == 12'h002) begin
      frm_m = val[2:0];
      send(instr, val, 1'b1, old, rd, 1'b1);
    end else begin
      send(instr, val, 1'b0, 32'h0, rd, 1'b0);
    end
  endtask

  initial begin
    arst_n_i = 1'b0;
    issue_valid_i = 1'b0;
    issue_instr_i = '0;
    issue_rs1_i = '0;
    issue_id_i = '0;
    result_ready_i = 1'b0;
    for (int i = 0; i < 32; i++) begin
      fpr_m[i] = '0;
    end
    // Operand signs walk through all four combinations
    for (int i = 0; i < SGNJ_ROUNDS; i++) begin
      op_a[i] = $random(seed);
      op_b[i] = $random(seed);
      op_a[i][31] = i[0];
      op_b[i][31] = i[1];
    end
    for (int i = 0; i < BURST; i++) begin
      burst_val[i] = $random(seed);
    end
    csr_val = $random(seed);
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);

    mv_w_x(5'd5, 32'hc0a0_0000);
    mv_x_w(5'd10, 5'd5);

    for (int i = 0; i < SGNJ_ROUNDS; i++) begin
      mv_w_x(5'd1, op_a[i]);
      mv_w_x(5'd2, op_b[i]);
      sgnj(3'b000, 5'd3, 5'd1, 5'd2);
      sgnj(3'b001, 5'd4, 5'd1, 5'd2);
      sgnj(3'b010, 5'd6, 5'd1, 5'd2);
      mv_x_w(5'd11, 5'd3);
      mv_x_w(5'd12, 5'd4);
      mv_x_w(5'd13, 5'd6);
    end

    // frm starts at RNE
    csrrw(5'd7, 12'h002, 32'hffff_fffd);
    csrrw(5'd8, 12'h002, csr_val);
    csrrw(5'd9, 12'h002, 32'h0000_0000);

    // Unknown opcode, wrong CSR, FMV with rs2 set
    send(32'h0000_0013, 32'h0, 1'b0, 32'h0, 5'd0, 1'b0);
    csrrw(5'd9, 12'h001, 32'h0000_0007);
    send(enc_fp(7'b1110000, 5'd3, 5'd5, 3'b000, 5'd10), 32'h0, 1'b0, 32'h0, 5'd0, 1'b0);
    csrrw(5'd9, 12'h002, 32'h0000_0004);

    for (int i = 0; i < BURST; i++) begin
      mv_w_x(5'(16 + i), burst_val[i]);
    end
    for (int i = 0; i < BURST; i++) begin
      mv_x_w(5'(16 + i), 5'(16 + i));
    end

    // Second op reads the first one's rd
    sgnj(3'b010, 5'd20, 5'd1, 5'd2);
    sgnj(3'b001, 5'd21, 5'd20, 5'd1);
    mv_x_w(5'd14, 5'd21);
    issue_valid_i <= 1'b0;

    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    repeat (4) @(negedge clk_i);
    assert (xfers == accepted && !result_valid_o) else begin
      errors++;
      $display("Got %0d results for %0d accepted instructions", xfers, accepted);
    end
    $display("Issued %0d, accepted %0d, results %0d, errors %0d",
             issued, accepted, xfers, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+verilog
verilog/fpu_ss_instr_pkg.sv
verilog/fpu_ss_csr_pkg.sv
verilog/fpu_ss_decoder.sv
verilog/fpu_ss_regfile.sv
verilog/fpu_ss_csr.sv
verilog/fpu_ss_controller.sv
verilog/fpu_ss_result_stage.sv
verilog/fpu_ss.sv
testbench/tb_fpu_ss.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the fpu_ss testbench with Verilator
set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_fpu_ss -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_fpu_ss" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  exit 1
fi
exit 0
